//--- verilog/cpu_dma_pkg.sv
/* CPU DMA receive queue package
   Widths, header layout, FIFO sizing and the shared word and record types */

package cpu_dma_pkg;

   ////////////////////
   // Widths
   localparam int DATA_WIDTH     = 32;
   localparam int CTRL_WIDTH     = DATA_WIDTH / 8;
   localparam int MAX_PKT_SIZE   = 2048;
   localparam int BYTE_SEL_WIDTH = $clog2(CTRL_WIDTH);
   localparam int BYTE_CNT_WIDTH = $clog2(MAX_PKT_SIZE) + 1;
   localparam int WORD_CNT_WIDTH = BYTE_CNT_WIDTH - BYTE_SEL_WIDTH;

   ////////////////////
   // FIFO sizing
   localparam int DATA_FIFO_DEPTH_BITS   = 9;
   localparam int LEN_FIFO_DEPTH_BITS    = 3;
   localparam int DATA_NEARLY_FULL_SPACE = 12;
   localparam int LEN_NEARLY_FULL_SPACE  = 1;

   ////////////////////
   // Module header word
   localparam int HDR_WORD_CNT_POS = 22;
   localparam int HDR_SRC_PORT_POS = 19;
   localparam int PORT_WIDTH       = HDR_WORD_CNT_POS - HDR_SRC_PORT_POS;
   localparam int HDR_PAD_WIDTH    = HDR_SRC_PORT_POS - BYTE_CNT_WIDTH;

   localparam logic [PORT_WIDTH-1:0] PORT_NUMBER = 3'd1;
   localparam logic [CTRL_WIDTH-1:0] HEADER_CTRL = 4'hF;

   typedef struct packed {
      logic [CTRL_WIDTH-1:0] ctrl;
      logic [DATA_WIDTH-1:0] data;
   } dma_word_t;

   // One entry per finished packet
   typedef struct packed {
      logic                      vld;
      logic [BYTE_CNT_WIDTH-1:0] byte_cnt;
   } pkt_rec_t;

   typedef struct packed {
      logic stored;
      logic dropped;
      logic removed;
      logic underrun;
      logic overrun;
   } rx_events_t;

   // Byte length to word length, rounded up
   function automatic logic [WORD_CNT_WIDTH-1:0] word_count(
      input logic [BYTE_CNT_WIDTH-1:0] byte_cnt);
      return byte_cnt[BYTE_CNT_WIDTH-1:BYTE_SEL_WIDTH] +
             WORD_CNT_WIDTH'(|byte_cnt[BYTE_SEL_WIDTH-1:0]);
   endfunction

endpackage

//--- verilog/fwft_fifo.sv
/* Synchronous first-word-fall-through FIFO
   Head entry is visible while not empty, with a programmable nearly-full flag */

module fwft_fifo #(
   parameter type entry_t           = logic [7:0],
   parameter int  DEPTH_BITS        = 3,
   parameter int  NEARLY_FULL_SPACE = 1
) (
   input  logic   clk,
   input  logic   reset,
   input  logic   wr_en,
   input  entry_t din,
   input  logic   rd_en,
   output entry_t dout,
   output logic   empty,
   output logic   full,
   output logic   nearly_full
);

   localparam int DEPTH = 1 << DEPTH_BITS;

   entry_t mem [DEPTH];

   logic [DEPTH_BITS-1:0] wr_ptr;
   logic [DEPTH_BITS-1:0] rd_ptr;
   logic [DEPTH_BITS:0]   count;
   logic                  do_wr;
   logic                  do_rd;

   // Writes to a full FIFO and reads from an empty one are ignored
   assign do_wr = wr_en && !full;
   assign do_rd = rd_en && !empty;

   assign empty       = (count == '0);
   assign full        = (count == (DEPTH_BITS+1)'(DEPTH));
   assign nearly_full = (int'(count) >= DEPTH - NEARLY_FULL_SPACE);

   // Head entry falls through
   assign dout = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (do_wr) begin
         mem[wr_ptr] <= din;
      end
   end

   ////////////////////
   // Pointers and occupancy
   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

//--- verilog/dma_rx_ingress.sv
/* DMA receive ingress
   Captures packet length, reorders payload to big endian and records packet status */

module dma_rx_ingress (
   input  logic                                      clk,
   input  logic                                      reset,
   input  logic                                      dma_wr,
   input  cpu_dma_pkg::dma_word_t                    dma_word,
   input  logic                                      dma_pkt_vld,
   input  logic                                      rx_queue_en,
   input  logic                                      data_full,
   input  logic                                      data_nearly_full,
   input  logic                                      len_nearly_full,
   output logic                                      data_wr_en,
   output cpu_dma_pkg::dma_word_t                    data_din,
   output logic                                      len_wr_en,
   output cpu_dma_pkg::pkt_rec_t                     len_din,
   output logic                                      dma_nearly_full,
   output logic [cpu_dma_pkg::BYTE_CNT_WIDTH-1:0]    rx_pkt_byte_cnt,
   output logic [cpu_dma_pkg::WORD_CNT_WIDTH-1:0]    rx_pkt_word_cnt,
   output logic                                      stored,
   output logic                                      dropped,
   output logic                                      overrun
);

   logic in_pkt;
   logic last_wr;
   logic first_wr;

   // The length word opens a packet and is never stored
   assign first_wr = dma_wr && !in_pkt;

   assign data_wr_en = dma_wr && in_pkt && !data_full;
   assign last_wr    = data_wr_en && (|dma_word.ctrl);

   ////////////////////
   // Byte reordering
   // Host side is little endian, user data path is big endian
   always_comb begin
      for (int k = 0; k < cpu_dma_pkg::CTRL_WIDTH; k++) begin
         data_din.ctrl[k] = dma_word.ctrl[cpu_dma_pkg::CTRL_WIDTH-1-k];
         data_din.data[8*k +: 8] = dma_word.data[cpu_dma_pkg::DATA_WIDTH-8-8*k +: 8];
      end
   end

   ////////////////////
   // Packet tracking
   always_ff @(posedge clk) begin
      if (reset) begin
         in_pkt          <= 1'b0;
         rx_pkt_byte_cnt <= '0;
         rx_pkt_word_cnt <= '0;
      end else begin
         if (first_wr) begin
            in_pkt          <= 1'b1;
            rx_pkt_byte_cnt <= dma_word.data[cpu_dma_pkg::BYTE_CNT_WIDTH-1:0];
            rx_pkt_word_cnt <= cpu_dma_pkg::word_count(
               dma_word.data[cpu_dma_pkg::BYTE_CNT_WIDTH-1:0]);
         end else if (dma_wr && in_pkt && (|dma_word.ctrl)) begin
            // Closes even when the last word was lost to a full FIFO
            in_pkt <= 1'b0;
         end
      end
   end

   // Status record of the packet just finished
   always_ff @(posedge clk) begin
      if (last_wr) begin
         len_din.vld      <= dma_pkt_vld;
         len_din.byte_cnt <= rx_pkt_byte_cnt;
      end
   end

   ////////////////////
   // Event pulses and flow control
   always_ff @(posedge clk) begin
      if (reset) begin
         len_wr_en       <= 1'b0;
         stored          <= 1'b0;
         dropped         <= 1'b0;
         overrun         <= 1'b0;
         dma_nearly_full <= 1'b0;
      end else begin
         len_wr_en <= last_wr;
         stored    <= last_wr && dma_pkt_vld;
         dropped   <= last_wr && !dma_pkt_vld;
         overrun   <= dma_wr && data_full;

         // Also held high while the queue is disabled
         dma_nearly_full <= data_nearly_full || len_nearly_full || !rx_queue_en;
      end
   end

endmodule

//--- verilog/rx_pkt_egress.sv
/* Receive queue egress
   Sends a header and payload for each good packet and discards bad ones */

module rx_pkt_egress (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   out_rdy,
   input  cpu_dma_pkg::dma_word_t data_dout,
   input  logic                   data_empty,
   input  cpu_dma_pkg::pkt_rec_t  len_dout,
   input  logic                   len_empty,
   output logic                   data_rd_en,
   output logic                   len_rd_en,
   output logic                   out_wr,
   output cpu_dma_pkg::dma_word_t out_word,
   output logic                   removed,
   output logic                   underrun
);

   typedef enum logic [1:0] {
      ST_WAIT = 2'd0,
      ST_XFER = 2'd1,
      ST_DROP = 2'd2
   } state_t;

   state_t state;
   state_t state_nxt;

   logic                   out_wr_nxt;
   cpu_dma_pkg::dma_word_t out_word_nxt;
   logic                   last_word;

   assign last_word = |data_dout.ctrl;

   ////////////////////
   // Output FSM
   always_comb begin
      state_nxt    = state;
      data_rd_en   = 1'b0;
      len_rd_en    = 1'b0;
      removed      = 1'b0;
      out_wr_nxt   = 1'b0;
      out_word_nxt = '0;

      case (state)
         // Only start once a whole packet sits in the data FIFO
         ST_WAIT: begin
            if (!len_empty) begin
               if (!len_dout.vld) begin
                  state_nxt = ST_DROP;
               end else if (out_rdy) begin
                  out_word_nxt.ctrl = cpu_dma_pkg::HEADER_CTRL;
                  out_word_nxt.data = {
                     cpu_dma_pkg::word_count(len_dout.byte_cnt),
                     cpu_dma_pkg::PORT_NUMBER,
                     {cpu_dma_pkg::HDR_PAD_WIDTH{1'b0}},
                     len_dout.byte_cnt
                  };
                  out_wr_nxt = 1'b1;
                  state_nxt  = ST_XFER;
               end
            end
         end

         ST_XFER: begin
            if (out_rdy) begin
               out_word_nxt = data_dout;
               out_wr_nxt   = 1'b1;
               data_rd_en   = 1'b1;
               if (last_word) begin
                  removed   = 1'b1;
                  len_rd_en = 1'b1;
                  state_nxt = ST_WAIT;
               end
            end
         end

         // Bad packet, most likely a DMA timeout
         ST_DROP: begin
            data_rd_en = 1'b1;
            if (last_word) begin
               len_rd_en = 1'b1;
               state_nxt = ST_WAIT;
            end
         end

         default: begin
            state_nxt = ST_WAIT;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state    <= ST_WAIT;
         out_wr   <= 1'b0;
         underrun <= 1'b0;
      end else begin
         state    <= state_nxt;
         out_wr   <= out_wr_nxt;
         underrun <= data_rd_en && data_empty;
      end
   end

   always_ff @(posedge clk) begin
      out_word <= out_word_nxt;
   end

endmodule

//--- verilog/cpu_dma_rx.sv
/* CPU DMA receive queue
   Host-to-card packet queue between the DMA engine and the user data path */

module cpu_dma_rx (
   input  logic                                   clk,
   input  logic                                   reset,
   input  logic                                   dma_wr,
   input  cpu_dma_pkg::dma_word_t                 dma_word,
   input  logic                                   dma_pkt_vld,
   input  logic                                   rx_queue_en,
   input  logic                                   out_rdy,
   output logic                                   dma_nearly_full,
   output logic                                   out_wr,
   output cpu_dma_pkg::dma_word_t                 out_word,
   output logic [cpu_dma_pkg::BYTE_CNT_WIDTH-1:0] rx_pkt_byte_cnt,
   output logic [cpu_dma_pkg::WORD_CNT_WIDTH-1:0] rx_pkt_word_cnt,
   output cpu_dma_pkg::rx_events_t                events
);

   logic                   data_wr_en;
   logic                   data_rd_en;
   cpu_dma_pkg::dma_word_t data_din;
   cpu_dma_pkg::dma_word_t data_dout;
   logic                   data_empty;
   logic                   data_full;
   logic                   data_nearly_full;

   logic                   len_wr_en;
   logic                   len_rd_en;
   cpu_dma_pkg::pkt_rec_t  len_din;
   cpu_dma_pkg::pkt_rec_t  len_dout;
   logic                   len_empty;
   logic                   len_nearly_full;

   ////////////////////
   // Input side
   dma_rx_ingress ingress (
      .clk              (clk),
      .reset            (reset),
      .dma_wr           (dma_wr),
      .dma_word         (dma_word),
      .dma_pkt_vld      (dma_pkt_vld),
      .rx_queue_en      (rx_queue_en),
      .data_full        (data_full),
      .data_nearly_full (data_nearly_full),
      .len_nearly_full  (len_nearly_full),
      .data_wr_en       (data_wr_en),
      .data_din         (data_din),
      .len_wr_en        (len_wr_en),
      .len_din          (len_din),
      .dma_nearly_full  (dma_nearly_full),
      .rx_pkt_byte_cnt  (rx_pkt_byte_cnt),
      .rx_pkt_word_cnt  (rx_pkt_word_cnt),
      .stored           (events.stored),
      .dropped          (events.dropped),
      .overrun          (events.overrun)
   );

   // Payload words
   fwft_fifo #(
      .entry_t           (cpu_dma_pkg::dma_word_t),
      .DEPTH_BITS        (cpu_dma_pkg::DATA_FIFO_DEPTH_BITS),
      .NEARLY_FULL_SPACE (cpu_dma_pkg::DATA_NEARLY_FULL_SPACE)
   ) data_fifo (
      .clk         (clk),
      .reset       (reset),
      .wr_en       (data_wr_en),
      .din         (data_din),
      .rd_en       (data_rd_en),
      .dout        (data_dout),
      .empty       (data_empty),
      .full        (data_full),
      .nearly_full (data_nearly_full)
   );

   // One record per complete packet in the data FIFO
   fwft_fifo #(
      .entry_t           (cpu_dma_pkg::pkt_rec_t),
      .DEPTH_BITS        (cpu_dma_pkg::LEN_FIFO_DEPTH_BITS),
      .NEARLY_FULL_SPACE (cpu_dma_pkg::LEN_NEARLY_FULL_SPACE)
   ) len_fifo (
      .clk         (clk),
      .reset       (reset),
      .wr_en       (len_wr_en),
      .din         (len_din),
      .rd_en       (len_rd_en),
      .dout        (len_dout),
      .empty       (len_empty),
      .full        (),
      .nearly_full (len_nearly_full)
   );

   ////////////////////
   // Output side
   rx_pkt_egress egress (
      .clk        (clk),
      .reset      (reset),
      .out_rdy    (out_rdy),
      .data_dout  (data_dout),
      .data_empty (data_empty),
      .len_dout   (len_dout),
      .len_empty  (len_empty),
      .data_rd_en (data_rd_en),
      .len_rd_en  (len_rd_en),
      .out_wr     (out_wr),
      .out_word   (out_word),
      .removed    (events.removed),
      .underrun   (events.underrun)
   );

endmodule

//--- bench/cpu_dma_rx_tb.sv
/* Testbench for the CPU DMA receive queue
   Directed packet tests checked against a queue of expected output words */

module cpu_dma_rx_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam logic [31:0] LFSR_SEED = 32'h6d02;
   localparam logic [31:0] LFSR_TAPS = 32'h80200003;

   logic                                   clk = 1'b0;
   logic                                   reset;
   logic                                   dma_wr;
   cpu_dma_pkg::dma_word_t                 dma_word;
   logic                                   dma_pkt_vld;
   logic                                   rx_queue_en;
   logic                                   out_rdy = 1'b0;
   logic                                   dma_nearly_full;
   logic                                   out_wr;
   cpu_dma_pkg::dma_word_t                 out_word;
   logic [cpu_dma_pkg::BYTE_CNT_WIDTH-1:0] rx_pkt_byte_cnt;
   logic [cpu_dma_pkg::WORD_CNT_WIDTH-1:0] rx_pkt_word_cnt;
   cpu_dma_pkg::rx_events_t                events;

   cpu_dma_pkg::dma_word_t exp_q[$];
   logic [31:0] data_lfsr   = LFSR_SEED;
   logic [31:0] rdy_lfsr    = LFSR_SEED;
   int          rdy_mode    = 0;  // 0 low, 1 high, 2 random
   logic        rdy_prev    = 1'b0;
   int          stored_cnt  = 0;
   int          dropped_cnt = 0;
   int          removed_cnt = 0;
   int          overrun_cnt = 0;
   string       test_name   = "reset";

   cpu_dma_rx dut (.*);

   always #20 clk = ~clk;

   function automatic logic [31:0] lfsr_next(input logic [31:0] state);
      return state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);
   endfunction

   // One LFSR step for each bit taken
   task automatic next_rand(input int nbits, output logic [31:0] value);
      value = '0;
      for (int k = 0; k < nbits; k++) begin
         value = {value[30:0], data_lfsr[0]};
         data_lfsr = lfsr_next(data_lfsr);
      end
   endtask

   task automatic report_failure(input string what);
      $display("%s: %s", test_name, what);
      $display("Checks failed");
      $fatal(1);
   endtask

   task automatic report_mismatch(input string what, input logic [35:0] expected,
                                  input logic [35:0] actual);
      $display("[FAIL] %s: %s expected %h actual %h", test_name, what, expected, actual);
      $display("Checks failed");
      $fatal(1);
   endtask

   // User side ready pattern
   always @(posedge clk) begin
      case (rdy_mode)
         0: out_rdy <= 1'b0;
         1: out_rdy <= 1'b1;
         default: begin
            out_rdy <= rdy_lfsr[0];
            rdy_lfsr = lfsr_next(rdy_lfsr);
         end
      endcase
   end

   ////////////////////
   // Output monitor
   always @(negedge clk) begin
      cpu_dma_pkg::dma_word_t expected;
      if (!reset) begin
         assert (!events.underrun) else report_failure("underrun pulse seen");
         stored_cnt  = stored_cnt + int'(events.stored);
         dropped_cnt = dropped_cnt + int'(events.dropped);
         removed_cnt = removed_cnt + int'(events.removed);
         overrun_cnt = overrun_cnt + int'(events.overrun);
         if (out_wr) begin
            assert (rdy_prev) else report_failure("out_wr after an edge with out_rdy low");
            assert (exp_q.size() != 0) else report_failure("output word nobody expected");
            expected = exp_q.pop_front();
            assert (out_word == expected) else report_mismatch("output word", expected, out_word);
         end
         rdy_prev = out_rdy;
      end
   end

   ////////////////////
   // Stimulus
   // Length word, then little endian payload with a one-hot mask on the last byte
   task automatic send_pkt(input int len, input logic vld, input logic expect_out);
      int          nwords;
      logic [31:0] data;
      logic [3:0]  mask;
      nwords = (len + 3) / 4;
      if (expect_out) begin
         exp_q.push_back({cpu_dma_pkg::HEADER_CTRL, 10'(nwords), cpu_dma_pkg::PORT_NUMBER,
                          7'd0, 12'(len)});
      end
      @(posedge clk);
      dma_wr      <= 1'b1;
      dma_word    <= {4'h0, 32'(len)};
      dma_pkt_vld <= 1'b0;
      for (int i = 0; i < nwords; i++) begin
         @(posedge clk);
         next_rand(32, data);
         mask = (i == nwords - 1) ? 4'(1 << (len - 4 * i - 1)) : 4'h0;
         dma_word    <= {mask, data};
         dma_pkt_vld <= vld;
         if (expect_out) begin
            exp_q.push_back({mask[0], mask[1], mask[2], mask[3],
                             data[7:0], data[15:8], data[23:16], data[31:24]});
         end
         if (i == 0) begin
            @(negedge clk);
            assert (rx_pkt_byte_cnt == 12'(len))
               else report_mismatch("rx_pkt_byte_cnt", 36'(len), 36'(rx_pkt_byte_cnt));
            assert (rx_pkt_word_cnt == 10'(nwords))
               else report_mismatch("rx_pkt_word_cnt", 36'(nwords), 36'(rx_pkt_word_cnt));
         end
      end
      @(posedge clk);
      dma_wr <= 1'b0;
   endtask

   task automatic wait_drained(input int limit);
      int n;
      n = 0;
      while (exp_q.size() != 0) begin
         @(negedge clk);
         n++;
         assert (n < limit) else report_failure("expected output words did not arrive");
      end
   endtask

   task automatic wait_level(input logic want, input int limit);
      int n;
      n = 0;
      while (dma_nearly_full !== want) begin
         @(negedge clk);
         n++;
         assert (n < limit) else report_failure("dma_nearly_full did not reach its level");
      end
   endtask

   task automatic wait_counts(input int stored_target, input int overrun_target,
                              input int limit);
      int n;
      n = 0;
      while (stored_cnt < stored_target || overrun_cnt < overrun_target) begin
         @(negedge clk);
         n++;
         assert (n < limit) else report_failure("stored or overrun pulses missing");
      end
   endtask

   task automatic check_count(input string what, input int expected, input int actual);
      assert (actual == expected) else report_mismatch(what, 36'(expected), 36'(actual));
   endtask

   ////////////////////
   // Tests
   task automatic good_packet();
      int stored_base;
      int removed_base;
      test_name = "good_packet";
      stored_base = stored_cnt;
      removed_base = removed_cnt;
      @(negedge clk);
      rdy_mode = 1;
      send_pkt(23, 1'b1, 1'b1);
      wait_drained(200);
      check_count("stored pulses", stored_base + 1, stored_cnt);
      check_count("removed pulses", removed_base + 1, removed_cnt);
   endtask

   // Bad packet vanishes, the good one behind it survives
   task automatic bad_packet();
      int dropped_base;
      int removed_base;
      test_name = "bad_packet";
      dropped_base = dropped_cnt;
      removed_base = removed_cnt;
      @(negedge clk);
      rdy_mode = 1;
      send_pkt(10, 1'b0, 1'b0);
      send_pkt(16, 1'b1, 1'b1);
      wait_drained(200);
      check_count("dropped pulses", dropped_base + 1, dropped_cnt);
      check_count("removed pulses", removed_base + 1, removed_cnt);
   endtask

   task automatic back_pressure();
      int lens[5] = '{1, 5, 64, 37, 100};
      int removed_base;
      test_name = "back_pressure";
      removed_base = removed_cnt;
      @(negedge clk);
      rdy_mode = 2;
      foreach (lens[k]) begin
         send_pkt(lens[k], 1'b1, 1'b1);
      end
      wait_drained(3000);
      check_count("removed pulses", removed_base + 5, removed_cnt);
   endtask

   task automatic nearly_full_flag();
      int stored_base;
      test_name = "nearly_full";
      @(negedge clk);
      rdy_mode = 0;
      @(posedge clk);
      rx_queue_en <= 1'b0;
      wait_level(1'b1, 10);
      @(posedge clk);
      rx_queue_en <= 1'b1;
      wait_level(1'b0, 10);
      // Fill the length FIFO with nothing leaving
      stored_base = stored_cnt;
      repeat (7) begin
         send_pkt(8, 1'b1, 1'b1);
      end
      wait_counts(stored_base + 7, 0, 20);
      wait_level(1'b1, 10);
      rdy_mode = 1;
      wait_drained(500);
      wait_level(1'b0, 10);
   endtask

   // More than 512 payload words with the user side stalled
   task automatic fifo_overrun();
      int stored_base;
      test_name = "fifo_overrun";
      @(negedge clk);
      rdy_mode = 0;
      stored_base = stored_cnt;
      send_pkt(2080, 1'b1, 1'b0);
      wait_counts(stored_base, 1, 20);
      check_count("stored pulses", stored_base, stored_cnt);
   endtask

   initial begin
      reset       <= 1'b1;
      dma_wr      <= 1'b0;
      dma_word    <= '0;
      dma_pkt_vld <= 1'b0;
      rx_queue_en <= 1'b1;
      repeat (10) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      assert (!out_wr && !dma_nearly_full && events == '0)
         else report_failure("outputs not idle after reset");

      good_packet();
      bad_packet();
      back_pressure();
      nearly_full_flag();
      fifo_overrun();

      if (exp_q.size() == 0) begin
         $display("All checks passed");
         $finish;
      end else begin
         report_failure("expected output words left over at the end");
      end
   end

endmodule

//--- cpu_dma_rx.f
verilog/cpu_dma_pkg.sv
verilog/fwft_fifo.sv
verilog/dma_rx_ingress.sv
verilog/rx_pkt_egress.sv
verilog/cpu_dma_rx.sv
bench/cpu_dma_rx_tb.sv

//--- Makefile
# Verilator build and run for the CPU DMA receive queue

TOOL       = verilator
FLAGS      = --binary --timing -j 0
LINT_FLAGS = --lint-only --timing
TOP        = cpu_dma_rx_tb
RTL_TOP    = cpu_dma_rx
FILE_LIST  = cpu_dma_rx.f
OBJ_DIR    = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILE_LIST)

clean:
	rm -rf $(OBJ_DIR)
